// File: logic/fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

`define XLEN        64                        // address and data width
`define RESET_PC    64'h0000_0000_8000_0000   // boot entry point

// icache geometry
`define ICACHE_WAYS 2                         // 1, 2 or 4
`define ICACHE_SETS 16
`define LINE_WORDS  4                         // 64-bit beats per line

// address split derived from the geometry
`define BEAT_BITS   ($clog2(`LINE_WORDS))
`define OFS_BITS    (`BEAT_BITS + 3)          // byte offset inside a line
`define SET_BITS    ($clog2(`ICACHE_SETS))

`define NOP_INST    32'h0000_0013             // addi x0, x0, 0

`endif

// File: logic/fetch_out.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_out (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  fetch_pkg::addr_t                     pc_i,
  input  logic [`ICACHE_WAYS-1:0]              hit_i,
  input  fetch_pkg::word_t [`ICACHE_WAYS-1:0]  word_i,
  input  logic                                 inst_ready_i,
  input  logic                                 redirected_i,
  input  logic                                 refill_done_i,
  input  logic                                 refill_err_i,
  output logic                                 inst_valid_o,
  output fetch_pkg::inst_t                     inst_o,
  output logic                                 fault_o,
  output logic                                 miss_req_o,
  output logic                                 advance_o
);
  import fetch_pkg::*;

  logic  any_hit;
  word_t hit_word;
  logic  pending_q;   // a refill is outstanding
  logic  pending_d;
  logic  stale_q;     // outstanding refill belongs to the old path
  logic  fault_q;     // bus error on the current pc

  // at most one way hits so the words are or-merged
  always_comb begin
    any_hit  = 1'b0;
    hit_word = '0;
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      if (hit_i[w]) begin
        any_hit  = 1'b1;
        hit_word = hit_word | word_i[w];
      end
    end
  end

  assign inst_valid_o = (any_hit || fault_q) && !redirected_i;  // redirect wins
  assign inst_o       = (inst_valid_o && !fault_q) ?
                        (pc_i[2] ? hit_word[63:32] : hit_word[31:0]) : `NOP_INST;
  assign fault_o      = fault_q && !redirected_i;
  assign advance_o    = inst_valid_o && inst_ready_i;
  // no new miss while an old-path burst drains
  assign miss_req_o   = !any_hit && !fault_q && !stale_q && !redirected_i;
  assign pending_d    = refill_done_i ? 1'b0 : (pending_q || miss_req_o);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending_q <= 1'b0;
      stale_q   <= 1'b0;
      fault_q   <= 1'b0;
    end else begin
      pending_q <= pending_d;
      stale_q   <= pending_d && (stale_q || redirected_i);  // clears with refill_done
      if (redirected_i || advance_o) begin
        fault_q <= 1'b0;                                   // taken or flushed
      end else if (refill_done_i && refill_err_i && !stale_q) begin
        fault_q <= 1'b1;
      end
    end
  end

endmodule

// File: logic/fetch_pkg.sv
`include "fetch_macros.svh"

package fetch_pkg;

  typedef logic [`XLEN-1:0] addr_t;   // fetch / bus address
  typedef logic [63:0]      word_t;   // one axi data beat
  typedef logic [31:0]      inst_t;   // one rv64 instruction, no rvc

  // redirect request from the back end
  typedef enum logic [1:0] {
    REDIR_NONE   = 2'd0,
    REDIR_BRANCH = 2'd1,  // branch or jalr resolved in ex
    REDIR_TRAP   = 2'd2,  // go to mtvec
    REDIR_MRET   = 2'd3   // back to mepc
  } redir_kind_e;

  // axi rresp encoding
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

  // line refill fsm
  typedef enum logic [1:0] {
    RF_IDLE = 2'd0,
    RF_ADDR = 2'd1,  // ar channel held
    RF_DATA = 2'd2   // collecting r beats
  } refill_state_e;

endpackage

// File: logic/icache_refill.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module icache_refill (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     miss_req_i,
  input  fetch_pkg::addr_t         miss_pc_i,
  input  logic                     fence_i_i,
  input  logic                     axi_ar_ready_i,
  input  logic                     axi_r_valid_i,
  input  fetch_pkg::word_t         axi_r_data_i,
  input  fetch_pkg::axi_resp_e     axi_r_resp_i,
  input  logic                     axi_r_last_i,
  output logic                     axi_ar_valid_o,
  output fetch_pkg::addr_t         axi_ar_addr_o,
  output logic [7:0]               axi_ar_len_o,
  output logic                     axi_r_ready_o,
  output fetch_pkg::addr_t         fill_addr_o,
  output logic [`BEAT_BITS-1:0]    fill_beat_o,
  output fetch_pkg::word_t         fill_data_o,
  output logic [`ICACHE_WAYS-1:0]  fill_we_o,     // one-hot victim
  output logic                     fill_commit_o,
  output logic                     refill_done_o,
  output logic                     refill_err_o
);
  import fetch_pkg::*;

  localparam int WAY_W = (`ICACHE_WAYS > 1) ? $clog2(`ICACHE_WAYS) : 1;

  refill_state_e         state_q;
  addr_t                 line_q;     // line address of the burst
  logic [`BEAT_BITS-1:0] beat_q;     // beat being collected
  logic [WAY_W-1:0]      victim_q;
  logic [WAY_W-1:0]      rr_q [`ICACHE_SETS];  // per-set round robin
  logic                  err_q;      // sticky, any non-okay beat so far
  logic                  fenced_q;   // fence.i seen during this burst

  logic                  r_hs;
  logic                  last_hs;
  logic                  beat_err;
  logic                  line_bad;
  logic [`SET_BITS-1:0]  miss_set;
  logic [`SET_BITS-1:0]  line_set;

  assign r_hs     = (state_q == RF_DATA) && axi_r_valid_i;  // rready is high in RF_DATA
  assign last_hs  = r_hs && axi_r_last_i;
  assign beat_err = (axi_r_resp_i != RESP_OKAY);            // exokay also spoils the line
  assign line_bad = err_q || beat_err;
  assign miss_set = miss_pc_i[`OFS_BITS +: `SET_BITS];
  assign line_set = line_q[`OFS_BITS +: `SET_BITS];

  // ar channel, held from registers until ready
  assign axi_ar_valid_o = (state_q == RF_ADDR);
  assign axi_ar_addr_o  = line_q;
  assign axi_ar_len_o   = 8'(`LINE_WORDS - 1);  // incr burst, one line
  assign axi_r_ready_o  = (state_q == RF_DATA);

  // fill port towards the ways
  assign fill_addr_o = line_q;
  assign fill_beat_o = beat_q;
  assign fill_data_o = axi_r_data_i;

  always_comb begin
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      fill_we_o[w] = r_hs && (victim_q == WAY_W'(w));
    end
  end

  assign fill_commit_o = last_hs && !line_bad && !fenced_q && !fence_i_i;
  assign refill_done_o = last_hs;
  assign refill_err_o  = last_hs && line_bad;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= RF_IDLE;
      beat_q   <= '0;
      victim_q <= '0;
      err_q    <= 1'b0;
      fenced_q <= 1'b0;
      for (int s = 0; s < `ICACHE_SETS; s++) begin
        rr_q[s] <= '0;
      end
    end else begin
      case (state_q)
        RF_IDLE: begin
          if (miss_req_i) begin               // only sampled here
            state_q  <= RF_ADDR;
            beat_q   <= '0;
            err_q    <= 1'b0;
            fenced_q <= 1'b0;
            victim_q <= rr_q[miss_set];
          end
        end
        RF_ADDR: begin
          if (axi_ar_ready_i) begin
            state_q <= RF_DATA;
          end
        end
        RF_DATA: begin
          if (r_hs) begin
            beat_q <= beat_q + 1'b1;
            if (beat_err) begin
              err_q <= 1'b1;
            end
            if (axi_r_last_i) begin
              state_q <= RF_IDLE;             // burst runs to the end, never aborted
            end
          end
        end
        default: state_q <= RF_IDLE;
      endcase
      if (fence_i_i && (state_q != RF_IDLE)) begin
        fenced_q <= 1'b1;                     // line may be stale, skip the commit
      end
      if (fill_commit_o) begin
        rr_q[line_set] <= (rr_q[line_set] == WAY_W'(`ICACHE_WAYS - 1)) ?
                          '0 : rr_q[line_set] + 1'b1;
      end
    end
  end

  // line address, latched on the accepted miss
  always_ff @(posedge clk) begin
    if ((state_q == RF_IDLE) && miss_req_i) begin
      line_q <= {miss_pc_i[`XLEN-1:`OFS_BITS], {`OFS_BITS{1'b0}}};
    end
  end

endmodule

// File: logic/icache_way.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module icache_way (
  input  logic                   clk,
  input  logic                   rst_n,
  input  fetch_pkg::addr_t       lookup_pc_i,
  input  fetch_pkg::addr_t       fill_addr_i,   // line aligned
  input  logic [`BEAT_BITS-1:0]  fill_beat_i,
  input  fetch_pkg::word_t       fill_data_i,
  input  logic                   fill_we_i,     // this way is the victim
  input  logic                   fill_commit_i, // last beat, line is clean
  input  logic                   flush_i,       // fence.i
  output logic                   hit_o,
  output fetch_pkg::word_t       word_o
);
  import fetch_pkg::*;

  localparam int TAG_W = `XLEN - `OFS_BITS - `SET_BITS;

  logic [TAG_W-1:0]        tag_mem [`ICACHE_SETS];
  word_t                   data_mem [`ICACHE_SETS * `LINE_WORDS];  // {set, beat}
  logic [`ICACHE_SETS-1:0] valid_q;

  logic [TAG_W-1:0]      lk_tag;
  logic [`SET_BITS-1:0]  lk_set;
  logic [`BEAT_BITS-1:0] lk_beat;
  logic [TAG_W-1:0]      fl_tag;
  logic [`SET_BITS-1:0]  fl_set;

  // address split
  assign lk_tag  = lookup_pc_i[`XLEN-1 -: TAG_W];
  assign lk_set  = lookup_pc_i[`OFS_BITS +: `SET_BITS];
  assign lk_beat = lookup_pc_i[3 +: `BEAT_BITS];  // pc[2] picks the half later
  assign fl_tag  = fill_addr_i[`XLEN-1 -: TAG_W];
  assign fl_set  = fill_addr_i[`OFS_BITS +: `SET_BITS];

  // combinational lookup on the registered pc
  assign hit_o  = valid_q[lk_set] && (tag_mem[lk_set] == lk_tag);
  assign word_o = data_mem[{lk_set, lk_beat}];

  // victim line goes invalid on its first beat, valid again only on commit
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;                      // flush beats a same-cycle commit
    end else if (fill_we_i) begin
      valid_q[fl_set] <= fill_commit_i;
    end
  end

  always_ff @(posedge clk) begin
    if (fill_we_i) begin
      data_mem[{fl_set, fill_beat_i}] <= fill_data_i;  // one beat per r handshake
    end
    if (fill_we_i && fill_commit_i) begin
      tag_mem[fl_set] <= fl_tag;
    end
  end

endmodule

// File: logic/if_stage.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module if_stage (
  input  logic                    clk,
  input  logic                    rst_n,
  // decode side
  input  logic                    inst_ready_i,   // low on mul / div stalls too
  output logic                    inst_valid_o,
  output fetch_pkg::inst_t        inst_o,
  output fetch_pkg::addr_t        pc_o,
  output logic                    fault_o,
  // redirects from ex / csr
  input  fetch_pkg::redir_kind_e  redir_kind_i,
  input  fetch_pkg::addr_t        redir_pc_i,
  input  fetch_pkg::addr_t        mtvec_i,
  input  fetch_pkg::addr_t        mepc_i,
  input  logic                    fence_i_i,
  // axi read channel
  output logic                    axi_ar_valid_o,
  input  logic                    axi_ar_ready_i,
  output fetch_pkg::addr_t        axi_ar_addr_o,
  output logic [7:0]              axi_ar_len_o,
  input  logic                    axi_r_valid_i,
  output logic                    axi_r_ready_o,
  input  fetch_pkg::word_t        axi_r_data_i,
  input  fetch_pkg::axi_resp_e    axi_r_resp_i,
  input  logic                    axi_r_last_i
);
  import fetch_pkg::*;

  logic                          redirected;
  logic                          advance;
  logic                          miss_req;
  logic [`ICACHE_WAYS-1:0]       way_hit;
  word_t [`ICACHE_WAYS-1:0]      way_word;
  addr_t                         fill_addr;
  logic [`BEAT_BITS-1:0]         fill_beat;
  word_t                         fill_data;
  logic [`ICACHE_WAYS-1:0]       fill_we;
  logic                          fill_commit;
  logic                          refill_done;
  logic                          refill_err;

  pc_gen u_pc_gen (
    .clk          (clk),
    .rst_n        (rst_n),
    .advance_i    (advance),
    .redir_kind_i (redir_kind_i),
    .redir_pc_i   (redir_pc_i),
    .mtvec_i      (mtvec_i),
    .mepc_i       (mepc_i),
    .pc_o         (pc_o),        // also the lookup address
    .redirected_o (redirected)
  );

  for (genvar g = 0; g < `ICACHE_WAYS; g++) begin : g_way
    icache_way u_way (
      .clk           (clk),
      .rst_n         (rst_n),
      .lookup_pc_i   (pc_o),
      .fill_addr_i   (fill_addr),
      .fill_beat_i   (fill_beat),
      .fill_data_i   (fill_data),
      .fill_we_i     (fill_we[g]),
      .fill_commit_i (fill_commit),
      .flush_i       (fence_i_i),
      .hit_o         (way_hit[g]),
      .word_o        (way_word[g])
    );
  end

  icache_refill u_refill (
    .clk            (clk),
    .rst_n          (rst_n),
    .miss_req_i     (miss_req),
    .miss_pc_i      (pc_o),
    .fence_i_i      (fence_i_i),
    .axi_ar_ready_i (axi_ar_ready_i),
    .axi_r_valid_i  (axi_r_valid_i),
    .axi_r_data_i   (axi_r_data_i),
    .axi_r_resp_i   (axi_r_resp_i),
    .axi_r_last_i   (axi_r_last_i),
    .axi_ar_valid_o (axi_ar_valid_o),
    .axi_ar_addr_o  (axi_ar_addr_o),
    .axi_ar_len_o   (axi_ar_len_o),
    .axi_r_ready_o  (axi_r_ready_o),
    .fill_addr_o    (fill_addr),
    .fill_beat_o    (fill_beat),
    .fill_data_o    (fill_data),
    .fill_we_o      (fill_we),
    .fill_commit_o  (fill_commit),
    .refill_done_o  (refill_done),
    .refill_err_o   (refill_err)
  );

  fetch_out u_fetch_out (
    .clk           (clk),
    .rst_n         (rst_n),
    .pc_i          (pc_o),
    .hit_i         (way_hit),
    .word_i        (way_word),
    .inst_ready_i  (inst_ready_i),
    .redirected_i  (redirected),
    .refill_done_i (refill_done),
    .refill_err_i  (refill_err),
    .inst_valid_o  (inst_valid_o),
    .inst_o        (inst_o),
    .fault_o       (fault_o),
    .miss_req_o    (miss_req),
    .advance_o     (advance)
  );

endmodule

// File: logic/pc_gen.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module pc_gen (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   advance_i,     // decode took the current inst
  input  fetch_pkg::redir_kind_e redir_kind_i,  // one-cycle request
  input  fetch_pkg::addr_t       redir_pc_i,    // branch / jalr target
  input  fetch_pkg::addr_t       mtvec_i,       // trap vector
  input  fetch_pkg::addr_t       mepc_i,        // mret return address
  output fetch_pkg::addr_t       pc_o,
  output logic                   redirected_o
);
  import fetch_pkg::*;

  addr_t pc_q;    // current fetch pc
  addr_t pc_d;
  addr_t pc_seq;  // fall-through, pc+4 only

  assign pc_seq = pc_q + addr_t'(4);

  // next pc select
  // any redirect beats a same-cycle advance
  always_comb begin
    pc_d         = pc_q;
    redirected_o = 1'b1;
    case (redir_kind_i)
      REDIR_BRANCH: pc_d = redir_pc_i;
      REDIR_TRAP:   pc_d = mtvec_i;
      REDIR_MRET:   pc_d = mepc_i;
      default: begin
        redirected_o = 1'b0;  // no redirect this cycle
        if (advance_i) begin
          pc_d = pc_seq;      // sequential fetch
        end
      end
    endcase
  end

  // holds when decode stalls or the line is still missing
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= `RESET_PC;
    end else begin
      pc_q <= pc_d;
    end
  end

  assign pc_o = pc_q;  // registered, feeds the way lookup directly

endmodule

// File: project.f
+incdir+logic
logic/fetch_pkg.sv
logic/pc_gen.sv
logic/icache_way.sv
logic/icache_refill.sv
logic/fetch_out.sv
logic/if_stage.sv
verification/axi_mem_model.sv
verification/if_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the fetch stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  -f project.f \
  --top-module if_stage_tb \
  -o sim_if_stage

out=$(./obj_dir/sim_if_stage)
echo "$out"

if echo "$out" | grep -q "^TEST PASSED$"; then
  exit 0
else
  exit 1
fi

// File: verification/axi_mem_model.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module axi_mem_model (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 ar_valid_i,
  input  fetch_pkg::addr_t     ar_addr_i,
  input  logic [7:0]           ar_len_i,
  input  logic                 r_ready_i,
  output logic                 ar_ready_o,
  output logic                 r_valid_o,
  output fetch_pkg::word_t     r_data_o,
  output fetch_pkg::axi_resp_e r_resp_o,
  output logic                 r_last_o
);
  import fetch_pkg::*;

  localparam addr_t BASE      = `RESET_PC;
  localparam int    MEM_WORDS = 512;

  word_t mem [MEM_WORDS];   // filled by the testbench
  addr_t err_line [8];      // line addresses that answer slverr
  int    n_err = 0;

  logic  busy;
  addr_t cur;               // burst start
  int    beat;
  int    last_beat;         // arlen of the accepted burst
  bit    ar_hs;
  bit    r_hs;

  function automatic logic is_err(addr_t a);
    for (int k = 0; k < n_err; k++) begin
      if (a[63:5] == err_line[k][63:5]) return 1'b1;
    end
    return 1'b0;
  endfunction

  initial begin
    ar_ready_o = 1'b0;
    r_valid_o  = 1'b0;
    r_data_o   = '0;
    r_resp_o   = RESP_OKAY;
    r_last_o   = 1'b0;
    busy       = 1'b0;
  end

  // handshakes seen at the rising edge, acted on at the falling one
  always @(posedge clk) begin
    ar_hs = ar_valid_i && ar_ready_o;
    r_hs  = r_valid_o && r_ready_i;
  end

  always @(negedge clk) begin
    addr_t a;
    int    idx;
    if (!rst_n) begin
      ar_ready_o = 1'b0;
      r_valid_o  = 1'b0;
      r_last_o   = 1'b0;
      busy       = 1'b0;
    end else begin
      if (ar_hs) begin
        busy      = 1'b1;
        cur       = ar_addr_i;
        last_beat = int'(ar_len_i);
        beat      = 0;
        ar_hs     = 1'b0;
      end
      if (r_hs) begin
        r_hs      = 1'b0;
        r_valid_o = 1'b0;
        if (r_last_o) begin
          busy = 1'b0;
        end else begin
          beat++;
        end
      end
      ar_ready_o = !busy && ($urandom % 4 != 0);   // random ar gaps
      if (busy && !r_valid_o && ($urandom % 3 != 0)) begin
        a         = cur + addr_t'(beat * 8);
        idx       = int'((a - BASE) >> 3);
        r_valid_o = 1'b1;
        r_last_o  = (beat == last_beat);          // burst length from the ar beat
        if (a < BASE || idx >= MEM_WORDS) begin
          r_data_o = '0;
          r_resp_o = RESP_DECERR;                 // outside the image
        end else begin
          r_data_o = mem[idx];
          r_resp_o = is_err(a) ? RESP_SLVERR : RESP_OKAY;
        end
      end
    end
  end

endmodule

// File: verification/if_stage_tb.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module if_stage_tb;
  import fetch_pkg::*;

  localparam addr_t BASE        = `RESET_PC;
  localparam int    MEM_WORDS   = 512;
  localparam int    UNIT_CYCLES = 80;   // worst fetch incl. a miss with gaps

  logic        clk = 1'b0;
  logic        rst_n;
  logic        inst_ready;
  redir_kind_e redir_kind;
  addr_t       redir_pc, mtvec, mepc;
  logic        fence_i;
  logic        inst_valid_o, fault_o;
  inst_t       inst_o;
  addr_t       pc_o;
  logic        ar_valid, ar_ready, r_valid, r_ready, r_last;
  addr_t       ar_addr;
  logic [7:0]  ar_len;
  word_t       r_data;
  axi_resp_e   r_resp;

  word_t  img [MEM_WORDS];   // reference image for expected values
  string  op_q[$];
  addr_t  a_q[$];
  word_t  d_q[$];
  int     errs = 0;
  int     n_pass = 0;
  int     n_fail = 0;
  addr_t  exp_pc;
  logic   limit_set = 1'b0;
  longint limit_ns;

  if_stage DUT (
    .clk(clk), .rst_n(rst_n), .inst_ready_i(inst_ready), .inst_valid_o(inst_valid_o),
    .inst_o(inst_o), .pc_o(pc_o), .fault_o(fault_o), .redir_kind_i(redir_kind),
    .redir_pc_i(redir_pc), .mtvec_i(mtvec), .mepc_i(mepc), .fence_i_i(fence_i),
    .axi_ar_valid_o(ar_valid), .axi_ar_ready_i(ar_ready), .axi_ar_addr_o(ar_addr),
    .axi_ar_len_o(ar_len), .axi_r_valid_i(r_valid), .axi_r_ready_o(r_ready),
    .axi_r_data_i(r_data), .axi_r_resp_i(r_resp), .axi_r_last_i(r_last)
  );

  axi_mem_model mem_model (
    .clk(clk), .rst_n(rst_n), .ar_valid_i(ar_valid), .ar_addr_i(ar_addr),
    .ar_len_i(ar_len), .r_ready_i(r_ready), .ar_ready_o(ar_ready), .r_valid_o(r_valid),
    .r_data_o(r_data), .r_resp_o(r_resp), .r_last_o(r_last)
  );

  always #10 clk = ~clk;

  // whole address folded in, so no two words look alike
  function automatic word_t fill_word(addr_t a);
    return {(a[31:0] + 32'd4) ^ a[63:32] ^ 32'h0bad_f00d, a[31:0] ^ a[63:32] ^ 32'h0bad_f00d};
  endfunction

  function automatic int mem_idx(addr_t a);
    return int'((a - BASE) >> 3);
  endfunction

  function automatic inst_t exp_inst(addr_t pc);
    word_t w;
    w = img[mem_idx(pc)];
    return pc[2] ? w[63:32] : w[31:0];   // little endian halves
  endfunction

  task automatic poke(addr_t a, word_t d);
    img[mem_idx(a)]           = d;
    mem_model.mem[mem_idx(a)] = d;
  endtask

  task automatic check_inst(inst_t got, inst_t exp);
    if (got !== exp) begin
      errs++;
      $display("ERROR %0t: inst %h, expected %h at pc %h", $time, got, exp, exp_pc);
    end
  endtask

  task automatic check_pc(addr_t got, addr_t exp);
    if (got !== exp) begin
      errs++;
      $display("ERROR %0t: pc %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_fault(logic got, logic exp);
    if (got !== exp) begin
      errs++;
      $display("ERROR %0t: fault %b, expected %b at pc %h", $time, got, exp, exp_pc);
    end
  endtask

  // with timed set ready stays high and every cycle must deliver
  task automatic fetch_n(int n, bit timed);
    int got;
    int cycles;
    got    = 0;
    cycles = 0;
    while (got < n) begin
      @(negedge clk);
      inst_ready = timed ? 1'b1 : ($urandom % 4 != 0);
      cycles++;
      #1;
      if (inst_valid_o && inst_ready) begin
        check_pc(pc_o, exp_pc);
        check_fault(fault_o, 1'b0);
        check_inst(inst_o, exp_inst(exp_pc));
        exp_pc += 4;
        got++;
      end
    end
    @(negedge clk);
    inst_ready = 1'b0;
    if (timed && cycles != n) begin
      errs++;
      $display("ERROR %0t: %0d hits took %0d cycles", $time, n, cycles);
    end
  endtask

  task automatic redirect(string op, addr_t target);
    @(negedge clk);
    inst_ready = 1'b1;             // an old-path transfer would show here
    redir_pc   = target + 64'h100; // wrong sources differ from target
    mtvec      = target + 64'h200;
    mepc       = target + 64'h300;
    case (op)
      "B": begin
        redir_kind = REDIR_BRANCH;
        redir_pc   = target;
      end
      "T": begin
        redir_kind = REDIR_TRAP;
        mtvec      = target;
      end
      default: begin
        redir_kind = REDIR_MRET;
        mepc       = target;
      end
    endcase
    #1;
    if (inst_valid_o) begin
      errs++;
      $display("ERROR %0t: valid high in the redirect cycle", $time);
    end
    @(negedge clk);
    redir_kind = REDIR_NONE;
    inst_ready = 1'b0;
    exp_pc     = target;
  endtask

  task automatic expect_fault();
    do begin
      @(negedge clk);
      #1;
    end while (!inst_valid_o);     // ready stays low while the fault is held
    check_fault(fault_o, 1'b1);
    check_pc(pc_o, exp_pc);
  endtask

  initial begin
    int     fd;
    int     r;
    int     units;
    int     e0;
    string  tok;
    string  rest;
    addr_t  a;
    word_t  d;
    void'($urandom(32'hdd92cd74));
    rst_n      = 1'b0;
    inst_ready = 1'b0;
    redir_kind = REDIR_NONE;
    redir_pc   = '0;
    mtvec      = '0;
    mepc       = '0;
    fence_i    = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      poke(BASE + addr_t'(i * 8), fill_word(BASE + addr_t'(i * 8)));
    end
    fd = $fopen("verification/if_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open the test data file");
      $display("TEST FAILED");
      $finish;
    end else begin
      units = 0;
      while ($fscanf(fd, "%s", tok) == 1) begin
        a = '0;
        d = '0;
        if (tok.substr(0, 0) == "#") begin
          r = $fgets(rest, fd);      // comment line
        end else if (tok == "M") begin
          r = $fscanf(fd, "%h %h", a, d);
          poke(a, d);
        end else if (tok == "E") begin
          r = $fscanf(fd, "%h", a);
          mem_model.err_line[mem_model.n_err] = a;
          mem_model.n_err++;
        end else begin
          if (tok == "P") r = $fscanf(fd, "%h %h", a, d);
          else if (tok != "C" && tok != "X") r = $fscanf(fd, "%h", a);
          op_q.push_back(tok);
          a_q.push_back(a);
          d_q.push_back(d);
          units += (tok == "F" || tok == "L" || tok == "I") ? int'(a) : 1;
        end
      end
      $fclose(fd);
      limit_ns  = longint'(units + 16 + op_q.size()) * UNIT_CYCLES * 20;
      limit_set = 1'b1;

      repeat (16) @(posedge clk);
      @(negedge clk);
      rst_n  = 1'b1;
      exp_pc = BASE;

      for (int t = 0; t < op_q.size(); t++) begin
        e0 = errs;
        case (op_q[t])
          "F": fetch_n(int'(a_q[t]), 1'b0);
          "L": fetch_n(int'(a_q[t]), 1'b1);
          "I": repeat (int'(a_q[t])) @(negedge clk);
          "C": begin
            @(negedge clk);
            fence_i = 1'b1;
            @(negedge clk);
            fence_i = 1'b0;
          end
          "P": poke(a_q[t], d_q[t]);
          "X": expect_fault();
          default: redirect(op_q[t], a_q[t]);
        endcase
        if (errs == e0) n_pass++;
        else n_fail++;
        $display("test %0d %s %h: %s", t, op_q[t], a_q[t], (errs == e0) ? "ok" : "failed");
      end

      $display("tests passed %0d, failed %0d", n_pass, n_fail);
      if (n_fail == 0) begin
        $display("TEST PASSED");
      end else begin
        $display("TEST FAILED");
      end
      $finish;
    end
  end

  // bound derived from the command list
  initial begin
    wait (limit_set);
    #(limit_ns);
    $display("watchdog expired, the run hung");
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: verification/if_testdata.txt
# load: M addr data (64-bit word), E line address that returns slverr
# tests: F n fetch, L n timed hit fetch, I n idle, B/T/R target redirect,
# C fence.i, X expect fault, P addr data memory change
M 80000000 0000009300000013
M 80000008 0020811300108093
M 80000010 0040821300308193
E 80000300
# sequential fetch over several lines with stalls
F 20
# refetch of the loaded range, one per cycle
B 80000000
L 20
# redirects, the first one while a refill runs
F 4
I 3
B 80000100
F 6
T 80000800
F 4
R 80000060
F 8
# bus error, cleared by a trap and seen again
B 80000300
X
T 80000300
X
T 80000800
F 2
# three lines in set 0, then fence and changed memory
B 80000200
F 8
B 80000400
F 8
B 80000000
F 8
C
P 80000008 cafe0137deadb0b7
B 80000000
F 4
